//--- common/displayPkg.sv
package displayPkg;

	typedef logic [9:0] countT; // raster counter, pixels or lines
	typedef logic [3:0] digitT; // one decimal digit
	typedef logic [15:0] addrT; // memory address
	typedef logic [15:0] wordT; // memory data
	typedef logic [23:0] rgbT; // 8 bits per channel
	typedef logic [4:0] glyphRowT; // leftmost cell in msb

	// horizontal timing in pixels
	localparam int H_VISIBLE = 640;
	localparam int H_FRONT = 16;
	localparam int H_SYNC = 96;
	localparam int H_BACK = 48;
	localparam int H_TOTAL = H_VISIBLE + H_FRONT + H_SYNC + H_BACK; // 800

	// vertical timing in lines
	localparam int V_VISIBLE = 480;
	localparam int V_FRONT = 10;
	localparam int V_SYNC = 2;
	localparam int V_BACK = 33;
	localparam int V_TOTAL = V_VISIBLE + V_FRONT + V_SYNC + V_BACK; // 525

	// glyph cell grid
	localparam int GLYPH_W = 5;
	localparam int GLYPH_H = 7;
	localparam int CELL_SCALE = 20; // screen pixels per cell side

	localparam int BOX_W = GLYPH_W * CELL_SCALE; // 100
	localparam int BOX_H = GLYPH_H * CELL_SCALE; // 140

	// box placement, all boxes share one top line
	localparam int BOX_TOP = 160;
	localparam int HUN_LEFT = 40;
	localparam int TEN_LEFT = 200;
	localparam int ONE_LEFT = 360;

	localparam rgbT FG_COLOR = 24'hFFFFFF; // white
	localparam rgbT BG_COLOR = 24'h000000; // black

	localparam int SCORE_MAX = 999; // three digits max
	localparam int BCD_STEPS = 10; // one shift per binary bit of SCORE_MAX

endpackage

//--- logic/vgaTiming.sv
`timescale 1ns/1ps

module vgaTiming (
	input logic clk,
	input logic reset,
	output displayPkg::countT hCount,
	output displayPkg::countT vCount,
	output logic hSyncRaw,
	output logic vSyncRaw,
	output logic bright,
	output logic frameStart
);

	logic lineEnd; // last pixel of a line
	logic frameEnd; // last line of a frame

	assign lineEnd = (hCount == displayPkg::countT'(displayPkg::H_TOTAL - 1));
	assign frameEnd = (vCount == displayPkg::countT'(displayPkg::V_TOTAL - 1));

	// pixel counter, one step per clk
	always_ff @(posedge clk) begin
		if (!reset) begin
			hCount <= '0;
		end else if (lineEnd) begin
			hCount <= '0;
		end else begin
			hCount <= hCount + 1'b1;
		end
	end

	// line counter, steps at end of each line
	always_ff @(posedge clk) begin
		if (!reset) begin
			vCount <= '0;
		end else if (lineEnd) begin
			if (frameEnd) begin
				vCount <= '0;
			end else begin
				vCount <= vCount + 1'b1;
			end
		end
	end

	// sync pulses sit after the front porch, active low
	assign hSyncRaw = !((hCount >= (displayPkg::H_VISIBLE + displayPkg::H_FRONT)) &&
		(hCount < (displayPkg::H_VISIBLE + displayPkg::H_FRONT + displayPkg::H_SYNC)));
	assign vSyncRaw = !((vCount >= (displayPkg::V_VISIBLE + displayPkg::V_FRONT)) &&
		(vCount < (displayPkg::V_VISIBLE + displayPkg::V_FRONT + displayPkg::V_SYNC)));

	assign bright = (hCount < displayPkg::H_VISIBLE) && (vCount < displayPkg::V_VISIBLE);

	// first pixel of vertical sync
	assign frameStart = (hCount == '0) &&
		(vCount == displayPkg::countT'(displayPkg::V_VISIBLE + displayPkg::V_FRONT));

endmodule

//--- scoreFetch/scoreFetch.sv
`timescale 1ns/1ps

module scoreFetch (
	input logic clk,
	input logic reset,
	input logic frameStart,
	input displayPkg::addrT countAddr,
	input displayPkg::wordT memData,
	output displayPkg::addrT memAddr,
	output logic memRead,
	output displayPkg::digitT digitHun,
	output displayPkg::digitT digitTen,
	output displayPkg::digitT digitOne
);

	typedef enum logic [2:0] {
		IDLE,
		READ,
		CAPTURE,
		CONVERT,
		PUBLISH
	} stateT;

	stateT state;
	logic [3:0] stepCount; // conversion shifts done
	logic [displayPkg::BCD_STEPS-1:0] binReg; // binary still to shift out
	logic [displayPkg::BCD_STEPS-1:0] clamped; // saturated memory word
	logic [11:0] bcdReg; // hundreds, tens, ones
	logic [11:0] bcdAdj; // bcdReg after add-three

	// digits of 5 and up overflow past 9 once doubled
	function automatic displayPkg::digitT addThree(input displayPkg::digitT nib);
		if (nib >= 4'd5) begin
			return nib + 4'd3;
		end
		return nib;
	endfunction

	always_comb begin
		if (memData > displayPkg::wordT'(displayPkg::SCORE_MAX)) begin
			clamped = displayPkg::BCD_STEPS'(displayPkg::SCORE_MAX); // show 999
		end else begin
			clamped = memData[displayPkg::BCD_STEPS-1:0];
		end
	end

	assign bcdAdj = {addThree(bcdReg[11:8]), addThree(bcdReg[7:4]), addThree(bcdReg[3:0])};

	// control path
	always_ff @(posedge clk) begin
		if (!reset) begin
			state <= IDLE;
			stepCount <= '0;
			memRead <= 1'b0;
			memAddr <= '0;
			digitHun <= '0;
			digitTen <= '0;
			digitOne <= '0;
		end else begin
			case (state)
				IDLE: begin
					if (frameStart) begin
						state <= READ;
						memRead <= 1'b1; // one clk strobe
						memAddr <= countAddr;
					end
				end
				READ: begin
					state <= CAPTURE; // data arrives next clk
					memRead <= 1'b0;
				end
				CAPTURE: begin
					state <= CONVERT;
					stepCount <= '0;
				end
				CONVERT: begin
					if (stepCount == 4'(displayPkg::BCD_STEPS - 1)) begin
						state <= PUBLISH;
					end
					stepCount <= stepCount + 1'b1;
				end
				PUBLISH: begin
					// all three at once, no torn digits on screen
					digitHun <= bcdReg[11:8];
					digitTen <= bcdReg[7:4];
					digitOne <= bcdReg[3:0];
					state <= IDLE;
				end
				default: state <= IDLE;
			endcase
		end
	end

	// shift-add-three datapath
	always_ff @(posedge clk) begin
		if (state == CAPTURE) begin
			binReg <= clamped;
			bcdReg <= '0;
		end else if (state == CONVERT) begin
			{bcdReg, binReg} <= {bcdAdj[10:0], binReg, 1'b0}; // msb of binary into bcd
		end
	end

endmodule

//--- glyphRender/glyphRom.sv
`timescale 1ns/1ps

module glyphRom (
	input displayPkg::digitT digit,
	input logic [2:0] row,
	output displayPkg::glyphRowT pattern
);

	logic [0:6][4:0] bitmap; // top row first

	always_comb begin
		case (digit)
			4'd0: bitmap = {5'b01110, 5'b10001, 5'b10011, 5'b10101,
				5'b11001, 5'b10001, 5'b01110};
			4'd1: bitmap = {5'b00100, 5'b01100, 5'b00100, 5'b00100,
				5'b00100, 5'b00100, 5'b01110};
			4'd2: bitmap = {5'b01110, 5'b10001, 5'b00001, 5'b00010,
				5'b00100, 5'b01000, 5'b11111};
			4'd3: bitmap = {5'b11111, 5'b00010, 5'b00100, 5'b00010,
				5'b00001, 5'b10001, 5'b01110};
			4'd4: bitmap = {5'b00010, 5'b00110, 5'b01010, 5'b10010,
				5'b11111, 5'b00010, 5'b00010};
			4'd5: bitmap = {5'b11111, 5'b10000, 5'b11110, 5'b00001,
				5'b00001, 5'b10001, 5'b01110};
			4'd6: bitmap = {5'b00110, 5'b01000, 5'b10000, 5'b11110,
				5'b10001, 5'b10001, 5'b01110};
			4'd7: bitmap = {5'b11111, 5'b00001, 5'b00010, 5'b00100,
				5'b01000, 5'b01000, 5'b01000};
			4'd8: bitmap = {5'b01110, 5'b10001, 5'b10001, 5'b01110,
				5'b10001, 5'b10001, 5'b01110};
			4'd9: bitmap = {5'b01110, 5'b10001, 5'b10001, 5'b01111,
				5'b00001, 5'b00010, 5'b01100};
			default: bitmap = '0; // codes 10 to 15 are blank
		endcase
	end

	// row 7 lies outside the 7-row cell
	always_comb begin
		if (row < 3'(displayPkg::GLYPH_H)) begin
			pattern = bitmap[row];
		end else begin
			pattern = '0;
		end
	end

endmodule

//--- glyphRender/pixelGen.sv
`timescale 1ns/1ps

module pixelGen (
	input logic clk,
	input logic reset,
	input displayPkg::countT hCount,
	input displayPkg::countT vCount,
	input logic hSyncRaw,
	input logic vSyncRaw,
	input logic bright,
	input displayPkg::digitT digitHun,
	input displayPkg::digitT digitTen,
	input displayPkg::digitT digitOne,
	output logic hSync,
	output logic vSync,
	output displayPkg::rgbT rgb
);

	logic inRows; // line within the box band
	logic inHun;
	logic inTen;
	logic inOne;
	logic inBox; // pixel in any digit box
	displayPkg::countT boxLeft; // left column of the hit box
	displayPkg::digitT boxDigit; // digit shown in that box
	displayPkg::countT offsetH; // pixel offset inside box
	displayPkg::countT offsetV; // line offset inside box
	displayPkg::countT colWide;
	displayPkg::countT rowWide;
	logic [2:0] cellCol;
	logic [2:0] cellRow;
	displayPkg::glyphRowT pattern;
	logic pixelOn;

	assign inRows = (vCount >= displayPkg::BOX_TOP) &&
		(vCount < (displayPkg::BOX_TOP + displayPkg::BOX_H));
	assign inHun = (hCount >= displayPkg::HUN_LEFT) &&
		(hCount < (displayPkg::HUN_LEFT + displayPkg::BOX_W));
	assign inTen = (hCount >= displayPkg::TEN_LEFT) &&
		(hCount < (displayPkg::TEN_LEFT + displayPkg::BOX_W));
	assign inOne = (hCount >= displayPkg::ONE_LEFT) &&
		(hCount < (displayPkg::ONE_LEFT + displayPkg::BOX_W));
	assign inBox = inRows && (inHun || inTen || inOne);

	// pick box origin and digit, boxes never overlap
	always_comb begin
		if (inHun) begin
			boxLeft = displayPkg::countT'(displayPkg::HUN_LEFT);
			boxDigit = digitHun;
		end else if (inTen) begin
			boxLeft = displayPkg::countT'(displayPkg::TEN_LEFT);
			boxDigit = digitTen;
		end else begin
			boxLeft = displayPkg::countT'(displayPkg::ONE_LEFT);
			boxDigit = digitOne;
		end
	end

	assign offsetH = hCount - boxLeft;
	assign offsetV = vCount - displayPkg::countT'(displayPkg::BOX_TOP);

	// scale down to glyph cells
	assign colWide = offsetH / displayPkg::countT'(displayPkg::CELL_SCALE);
	assign rowWide = offsetV / displayPkg::countT'(displayPkg::CELL_SCALE);
	assign cellCol = colWide[2:0]; // 0..4 inside a box
	assign cellRow = rowWide[2:0]; // 0..6 inside a box

	glyphRom glyphRom_inst (
		.digit(boxDigit),
		.row(cellRow),
		.pattern(pattern)
	);

	// msb is the leftmost cell
	assign pixelOn = bright && inBox && pattern[3'(displayPkg::GLYPH_W - 1) - cellCol];

	// colour and syncs leave on the same edge
	always_ff @(posedge clk) begin
		if (!reset) begin
			rgb <= displayPkg::BG_COLOR;
			hSync <= 1'b1;
			vSync <= 1'b1;
		end else begin
			rgb <= pixelOn ? displayPkg::FG_COLOR : displayPkg::BG_COLOR;
			hSync <= hSyncRaw;
			vSync <= vSyncRaw;
		end
	end

endmodule

//--- logic/counterDisplay.sv
`timescale 1ns/1ps

module counterDisplay (
	input logic clk,
	input logic reset,
	input displayPkg::addrT countAddr,
	input displayPkg::wordT memData,
	output displayPkg::addrT memAddr,
	output logic memRead,
	output logic hSync,
	output logic vSync,
	output displayPkg::rgbT rgb
);

	displayPkg::countT hCount;
	displayPkg::countT vCount;
	logic hSyncRaw; // undelayed syncs
	logic vSyncRaw;
	logic bright;
	logic frameStart;
	displayPkg::digitT digitHun;
	displayPkg::digitT digitTen;
	displayPkg::digitT digitOne;

	vgaTiming vgaTiming_inst (
		.clk(clk),
		.reset(reset),
		.hCount(hCount),
		.vCount(vCount),
		.hSyncRaw(hSyncRaw),
		.vSyncRaw(vSyncRaw),
		.bright(bright),
		.frameStart(frameStart)
	);

	scoreFetch scoreFetch_inst (
		.clk(clk),
		.reset(reset),
		.frameStart(frameStart),
		.countAddr(countAddr),
		.memData(memData),
		.memAddr(memAddr),
		.memRead(memRead),
		.digitHun(digitHun),
		.digitTen(digitTen),
		.digitOne(digitOne)
	);

	pixelGen pixelGen_inst (
		.clk(clk),
		.reset(reset),
		.hCount(hCount),
		.vCount(vCount),
		.hSyncRaw(hSyncRaw),
		.vSyncRaw(vSyncRaw),
		.bright(bright),
		.digitHun(digitHun),
		.digitTen(digitTen),
		.digitOne(digitOne),
		.hSync(hSync),
		.vSync(vSync),
		.rgb(rgb)
	);

endmodule

//--- bench/counterDisplayTb.sv
`timescale 1ns/1ps

module counterDisplayTb;

	localparam int RANDOM_POINTS = 12; // background picks per frame
	localparam int REWRITE_LINE = 240; // mid-frame score rewrite inside the box band

	logic clk;
	logic reset;
	displayPkg::addrT countAddr;
	displayPkg::wordT memData;
	displayPkg::addrT memAddr;
	logic memRead;
	logic hSync;
	logic vSync;
	displayPkg::rgbT rgb;

	displayPkg::wordT memWords [0:65535]; // memory model contents
	displayPkg::addrT fileAddr; // score address from the file
	displayPkg::wordT frameScore [$]; // stored at line 0 of each frame
	displayPkg::wordT frameRewrite [$]; // stored at REWRITE_LINE
	logic frameHasRewrite [$];
	int sampleFrame [$]; // frame index of each file sample
	int sampleKey [$]; // line * H_TOTAL + column
	displayPkg::rgbT sampleRgb [$];
	displayPkg::rgbT frameExpect [int]; // file samples of the frame on screen
	logic backgroundSpot [int]; // random points outside the boxes
	int sampleHits; // file samples actually compared
	int tbH = -1; // position shown on rgb or -1 in reset
	int tbV = -1;
	logic fileLoaded;

	counterDisplay counterDisplay_inst (
		.clk(clk),
		.reset(reset),
		.countAddr(countAddr),
		.memData(memData),
		.memAddr(memAddr),
		.memRead(memRead),
		.hSync(hSync),
		.vSync(vSync),
		.rgb(rgb)
	);

	always #2 clk = !clk; // 4 ns period

	task automatic failRun(input string reason);
		$display("%s", reason);
		$display("Regression failed");
		$fatal(1, "run stopped at first error");
	endtask

	task automatic checkRgb(input string name, input displayPkg::rgbT expected,
		input displayPkg::rgbT actual);
		if (actual !== expected) begin
			failRun($sformatf("mismatch %s expected %h got %h at column %0d line %0d",
				name, expected, actual, tbH, tbV));
		end
	endtask

	task automatic checkAddr(input string name, input displayPkg::addrT expected,
		input displayPkg::addrT actual);
		if (actual !== expected) begin
			failRun($sformatf("mismatch %s expected %h got %h at column %0d line %0d",
				name, expected, actual, tbH, tbV));
		end
	endtask

	task automatic checkSync(input string name, input logic expected, input logic actual);
		if (actual !== expected) begin
			failRun($sformatf("mismatch %s expected %h got %h at column %0d line %0d",
				name, expected, actual, tbH, tbV));
		end
	endtask

	// 100x140 boxes from BOX_TOP at the three left columns
	function automatic logic inDigitBox(input int x, input int y);
		logic inBand;
		inBand = (y >= displayPkg::BOX_TOP) && (y < displayPkg::BOX_TOP + displayPkg::BOX_H);
		return inBand &&
			((x >= displayPkg::HUN_LEFT && x < displayPkg::HUN_LEFT + displayPkg::BOX_W) ||
			(x >= displayPkg::TEN_LEFT && x < displayPkg::TEN_LEFT + displayPkg::BOX_W) ||
			(x >= displayPkg::ONE_LEFT && x < displayPkg::ONE_LEFT + displayPkg::BOX_W));
	endfunction

	task automatic loadStimulus();
		int fd;
		int code;
		int need;
		int pixCol;
		int pixLine;
		logic [127:0] keyword;
		logic [2047:0] restLine;
		displayPkg::wordT word;
		displayPkg::rgbT color;
		fd = $fopen("bench/stimulus.txt", "r");
		if (fd == 0) begin
			failRun("cannot open bench/stimulus.txt");
		end
		while ($fscanf(fd, "%s", keyword) == 1) begin
			need = 1;
			if (keyword == "#") begin
				code = $fgets(restLine, fd); // rest of a comment line
				need = 0;
			end else if (keyword == "addr") begin
				code = $fscanf(fd, "%h", fileAddr);
			end else if (keyword == "frame") begin
				code = $fscanf(fd, "%h", word);
				frameScore.push_back(word);
				frameRewrite.push_back('0);
				frameHasRewrite.push_back(1'b0);
			end else if (keyword == "rewrite" && frameScore.size() > 0) begin
				code = $fscanf(fd, "%h", word);
				frameRewrite[frameRewrite.size() - 1] = word;
				frameHasRewrite[frameHasRewrite.size() - 1] = 1'b1;
			end else if (keyword == "pixel" && frameScore.size() > 0) begin
				code = $fscanf(fd, "%d %d %h", pixCol, pixLine, color);
				need = 3;
				sampleFrame.push_back(frameScore.size() - 1);
				sampleKey.push_back(pixLine * displayPkg::H_TOTAL + pixCol);
				sampleRgb.push_back(color);
			end else begin
				failRun("unknown or misplaced keyword in bench/stimulus.txt");
			end
			if (code < need) begin
				failRun("malformed value in bench/stimulus.txt");
			end
		end
		$fclose(fd);
		if (frameScore.size() == 0) begin
			failRun("bench/stimulus.txt holds no frames");
		end
	endtask

	task automatic runFrame(input int f);
		int key;
		int x;
		int y;
		logic hExpect;
		logic vExpect;
		logic readExpect;
		logic dataDue = 1'b0; // memData owed this cycle
		displayPkg::addrT readAddr = '0;
		frameExpect.delete();
		backgroundSpot.delete();
		for (int i = 0; i < sampleFrame.size(); i++) begin
			if (sampleFrame[i] == f) begin
				frameExpect[sampleKey[i]] = sampleRgb[i];
			end
		end
		while (backgroundSpot.size() < RANDOM_POINTS) begin
			x = $urandom_range(displayPkg::H_VISIBLE - 1, 0);
			y = $urandom_range(displayPkg::V_VISIBLE - 1, 0);
			if (!inDigitBox(x, y)) begin
				backgroundSpot[y * displayPkg::H_TOTAL + x] = 1'b1;
			end
		end
		for (tbV = 0; tbV < displayPkg::V_TOTAL; tbV++) begin
			for (tbH = 0; tbH < displayPkg::H_TOTAL; tbH++) begin
				@(posedge clk);
				#0.5;
				key = tbV * displayPkg::H_TOTAL + tbH;
				if (dataDue) begin
					memData = memWords[readAddr]; // one clk after the strobe
				end else begin
					memData = displayPkg::wordT'($urandom); // junk between reads
				end
				dataDue = memRead;
				readAddr = memAddr;
				if (tbH == 0 && tbV == 0) begin
					memWords[fileAddr] = frameScore[f];
				end
				if (tbH == 0 && tbV == REWRITE_LINE && frameHasRewrite[f]) begin
					memWords[fileAddr] = frameRewrite[f];
				end
				hExpect = !(tbH >= displayPkg::H_VISIBLE + displayPkg::H_FRONT &&
					tbH < displayPkg::H_VISIBLE + displayPkg::H_FRONT + displayPkg::H_SYNC);
				vExpect = !(tbV >= displayPkg::V_VISIBLE + displayPkg::V_FRONT &&
					tbV < displayPkg::V_VISIBLE + displayPkg::V_FRONT + displayPkg::V_SYNC);
				readExpect = (tbH == 0 && tbV == displayPkg::V_VISIBLE + displayPkg::V_FRONT);
				checkSync("hSync", hExpect, hSync);
				checkSync("vSync", vExpect, vSync);
				checkSync("memRead", readExpect, memRead); // lands with the vSync fall
				if (memRead) begin
					checkAddr("memAddr", fileAddr, memAddr);
				end
				if (frameExpect.exists(key)) begin
					checkRgb("rgb", frameExpect[key], rgb);
					sampleHits++;
				end else if (tbH >= displayPkg::H_VISIBLE || tbV >= displayPkg::V_VISIBLE) begin
					checkRgb("rgb", displayPkg::BG_COLOR, rgb); // blanking
				end else if (f == 0 && key == 0) begin
					checkRgb("rgb", displayPkg::BG_COLOR, rgb); // first clock out of reset
				end else if (backgroundSpot.exists(key)) begin
					checkRgb("rgb", displayPkg::BG_COLOR, rgb);
				end
			end
		end
	endtask

	initial begin
		clk = 1'b0;
		reset = 1'b0;
		countAddr = '0;
		memData = '0;
		fileLoaded = 1'b0;
		sampleHits = 0;
		void'($urandom(89));
		for (int i = 0; i < 65536; i++) begin
			memWords[i] = displayPkg::wordT'(i) ^ 16'hC35A; // distinct word per address
		end
		loadStimulus();
		fileLoaded = 1'b1;
		repeat (8) begin
			@(posedge clk);
			#0.5;
			countAddr = fileAddr;
			checkRgb("rgb", displayPkg::BG_COLOR, rgb);
			checkSync("hSync", 1'b1, hSync);
			checkSync("vSync", 1'b1, vSync);
			checkSync("memRead", 1'b0, memRead);
			checkAddr("memAddr", '0, memAddr);
		end
		reset = 1'b1;
		for (int f = 0; f < frameScore.size(); f++) begin
			runFrame(f);
		end
		if (sampleHits == sampleFrame.size()) begin
			$display("Regression passed");
			$finish;
		end else begin
			failRun($sformatf("only %0d of %0d file samples fell inside the raster",
				sampleHits, sampleFrame.size()));
		end
	end

	// watchdog allows one spare frame plus reset
	initial begin
		longint limitNs;
		wait (fileLoaded);
		limitNs = longint'(frameScore.size() + 1) * displayPkg::H_TOTAL * displayPkg::V_TOTAL * 4
			+ 1000;
		#(limitNs);
		failRun("watchdog expired before the raster finished");
	end

endmodule

//--- bench/stimulus.txt
# addr <hex address> | frame <hex score word> | rewrite <hex word> stored at line 240
# pixel <column> <line> <expected rgb hex> for the frame of its block
# each frame shows the word read in the previous frame and the first one shows 000
addr 0040
frame 007B
pixel 70 170 ffffff
pixel 50 170 000000
pixel 250 230 ffffff
pixel 450 250 ffffff
pixel 410 250 000000
pixel 700 100 000000
frame 01C8
pixel 90 170 ffffff
pixel 50 190 000000
pixel 370 170 ffffff
pixel 250 230 000000
pixel 290 290 ffffff
pixel 299 299 ffffff
pixel 300 299 000000
pixel 299 300 000000
frame 0315
pixel 110 170 ffffff
pixel 50 170 000000
pixel 210 190 ffffff
pixel 230 190 000000
pixel 370 230 ffffff
pixel 450 230 000000
pixel 100 500 000000
# the rewrite at line 240 must not tear this frame and shows 999 next frame
frame 0005
rewrite 0BB8
pixel 50 170 ffffff
pixel 210 230 000000
pixel 230 230 ffffff
pixel 70 270 ffffff
pixel 50 270 000000
pixel 390 290 ffffff
pixel 430 290 000000
frame 0040
pixel 50 190 ffffff
pixel 70 190 000000
pixel 390 230 ffffff
pixel 370 230 000000
pixel 270 270 ffffff
pixel 250 270 000000
frame 0000
pixel 50 190 ffffff
pixel 90 190 000000
pixel 230 190 ffffff
pixel 210 210 ffffff
pixel 430 170 ffffff
pixel 370 170 000000

//--- project.f
common/displayPkg.sv
logic/vgaTiming.sv
scoreFetch/scoreFetch.sv
glyphRender/glyphRom.sv
glyphRender/pixelGen.sv
logic/counterDisplay.sv
bench/counterDisplayTb.sv

//--- Makefile
SOURCES := $(shell grep -v '^+' project.f)

.PHONY: all run clean

all: run

obj_dir/VcounterDisplayTb: project.f $(SOURCES)
	verilator --binary --timing -Wno-fatal --top-module counterDisplayTb -f project.f

run: obj_dir/VcounterDisplayTb bench/stimulus.txt
	./obj_dir/VcounterDisplayTb

clean:
	rm -rf obj_dir
